/* filelist.f */
design/playfield_pkg.sv
design/line_timing.sv
design/line_address.sv
design/bitmap_fetch.sv
design/pixel_expand.sv
design/pixel_scanout.sv
design/video_playfield.sv
testbench/tb_clock.sv
testbench/playfield_sva.sv
testbench/tb_video_playfield.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_video_playfield
FILELIST  := filelist.f
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* testbench/tb_video_playfield.sv */
// directed tests of the bitmap playfield, 320 counts per line, 4 visible lines per frame
// video RAM model covers 4096 words, random contents never hold the border byte
module tb_video_playfield;
    localparam int LEFT           = 0;
    localparam int RIGHT          = 96;       // 96 scanout cycles per line
    localparam int TIMEOUT_CYCLES = 5 * 40 * 320 + 4000;

    logic                   clk;
    logic                   reset;
    playfield_pkg::hres_t   h_count = '0;
    logic [1:0]             v_count = '0;       // wraps after 4 lines
    logic                   line_last = 1'b0;
    logic                   frame_last = 1'b0;
    logic                   req_q = 1'b0;       // read issued at the last edge
    playfield_pkg::addr_t   req_addr_q = '0;
    playfield_pkg::word_t   vram_data = '0;
    int                     cycles = 0;
    playfield_pkg::word_t   mem [4096];
    playfield_pkg::bpp_t    pf_bpp;
    playfield_pkg::addr_t   pf_start;
    playfield_pkg::word_t   pf_line_len;
    playfield_pkg::color_t  pf_colorbase, border;
    logic [1:0]             pf_h_repeat, pf_v_repeat;
    logic                   pf_blank;
    logic                   vram_sel;
    playfield_pkg::addr_t   vram_addr;
    playfield_pkg::color_t  pf_color_index;
    integer                 seed;
    int                     error_count;

    tb_clock clock0 (.clk(clk), .reset_o(reset));

    video_playfield #(.TOTAL_WIDTH(320), .OFFSCREEN_WIDTH(160)) dut0 (
        .clk(clk), .reset_i(reset), .v_visible_i(1'b1), .h_count_i(h_count),
        .h_line_last_pixel_i(line_last), .last_frame_pixel_i(frame_last),
        .border_color_i(border), .vid_left_i(11'(LEFT)), .vid_right_i(11'(RIGHT)),
        .vram_sel_o(vram_sel), .vram_addr_o(vram_addr), .vram_data_i(vram_data),
        .pf_blank_i(pf_blank), .pf_start_addr_i(pf_start), .pf_line_len_i(pf_line_len),
        .pf_colorbase_i(pf_colorbase), .pf_bpp_i(pf_bpp), .pf_h_repeat_i(pf_h_repeat),
        .pf_v_repeat_i(pf_v_repeat), .pf_color_index_o(pf_color_index)
    );

    always @(negedge clk) begin                 // video timing, every line visible
        h_count    <= (h_count == 11'd319) ? 11'd0 : h_count + 11'd1;
        line_last  <= (h_count == 11'd318);
        frame_last <= (h_count == 11'd318) && (v_count == 2'd3);
        if (h_count == 11'd319) begin
            v_count <= v_count + 2'd1;
        end
    end

    always @(negedge clk) begin                 // data in the cycle after the select edge
        if (req_q) begin
            vram_data <= mem[req_addr_q[11:0]];
        end
        req_q      <= vram_sel;
        req_addr_q <= vram_addr;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run went past %0d clock cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %0t %s: got %0h, expected %0h", $time, what, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fill_memory();
        logic [31:0]          rnd;
        playfield_pkg::word_t w;
        for (int i = 0; i < 4096; i++) begin
            rnd = $random(seed);
            w   = rnd[15:0];
            if (w[15:8] == 8'hEE) w[15:8] = 8'h11;  // keep the border byte out
            if (w[7:0] == 8'hEE) w[7:0] = 8'h11;
            mem[i] = w;
        end
    endtask

    // pixel j of a line that starts at word ls
    function automatic playfield_pkg::color_t expected_pixel(input playfield_pkg::addr_t ls,
                                                              input playfield_pkg::bpp_t bpp,
                                                              input int j);
        playfield_pkg::word_t w;
        logic [7:0]           lo;
        case (bpp)
            playfield_pkg::BPP_1_ATTR: begin
                w  = mem[12'(ls + 16'(j / 8))];
                lo = w[7:0] << (j % 8);         // msb is the leftmost pixel
                return {4'h0, lo[7] ? w[15:12] : w[11:8]};
            end
            playfield_pkg::BPP_4: begin
                w = mem[12'(ls + 16'(j / 4))] << (4 * (j % 4));
                return {4'h0, w[15:12]};
            end
            default: begin
                w = mem[12'(ls + 16'(j / 2))];
                return (j % 2 == 0) ? w[15:8] : w[7:0];
            end
        endcase
    endfunction

    task automatic configure(input playfield_pkg::bpp_t bpp, input logic [1:0] h_rep,
                             input logic [1:0] v_rep, input playfield_pkg::color_t cb,
                             input playfield_pkg::addr_t start);
        pf_bpp       <= bpp;
        pf_h_repeat  <= h_rep;
        pf_v_repeat  <= v_rep;
        pf_colorbase <= cb;
        pf_start     <= start;
    endtask

    task automatic wait_frame_start();          // returns with h 0 of line 0 next
        do @(negedge clk); while (!(h_count == 11'd319 && v_count == 2'd3));
    endtask

    // one whole line, pixels checked from the first non-border colour on
    task automatic check_line(input playfield_pkg::addr_t ls);
        int                    npix;
        int                    rep;
        int                    k;
        logic                  started;
        logic                  seen_read;
        playfield_pkg::addr_t  first_addr;
        playfield_pkg::color_t bord;
        playfield_pkg::color_t expv;
        rep        = int'(pf_h_repeat) + 1;
        npix       = (RIGHT - LEFT) / rep;
        k          = 0;
        started    = 1'b0;
        seen_read  = 1'b0;
        first_addr = '0;
        bord       = border ^ pf_colorbase;
        for (int i = 0; i < 320; i++) begin
            @(negedge clk);
            if (vram_sel && !seen_read) begin
                seen_read  = 1'b1;
                first_addr = vram_addr;
            end
            if (i >= 100) begin                 // border placed at fetch start
                if (!started && pf_color_index != bord) started = 1'b1;
                if (started) begin
                    expv = (k < npix * rep) ? expected_pixel(ls, pf_bpp, k / rep) ^ pf_colorbase
                                            : bord;
                    check_value(32'(pf_color_index), 32'(expv), "pixel colour");
                    k++;
                end
            end
        end
        check_value(32'(started), 32'd1, "pixels shown on line");
        check_value(32'(seen_read), 32'd1, "reads on line");
        check_value(32'(first_addr), 32'(ls), "first read address of line");
    endtask

    task automatic run_frame();
        for (int line = 0; line < 4; line++) begin
            check_line(pf_start + 16'(line / (int'(pf_v_repeat) + 1)) * pf_line_len);
        end
    endtask

    task automatic test_reset();
        do @(negedge clk); while (reset);
        check_value(32'(vram_sel), 32'd0, "select after reset");
        check_value(32'(pf_color_index), 32'(pf_colorbase), "colour after reset");
    endtask

    task automatic test_8bpp();
        configure(playfield_pkg::BPP_8, 2'd0, 2'd0, 8'h00, 16'h0100);
        wait_frame_start();
        run_frame();
        configure(playfield_pkg::BPP_8, 2'd2, 2'd0, 8'h5A, 16'h0100);
        wait_frame_start();
        run_frame();
    endtask

    task automatic test_modes();
        configure(playfield_pkg::BPP_4, 2'd0, 2'd0, 8'h30, 16'h0300);
        wait_frame_start();
        run_frame();
        configure(playfield_pkg::BPP_1_ATTR, 2'd1, 2'd0, 8'h80, 16'h0500);
        wait_frame_start();
        run_frame();
    endtask

    task automatic test_vrepeat();
        configure(playfield_pkg::BPP_8, 2'd0, 2'd1, 8'h0F, 16'h0700);
        wait_frame_start();
        run_frame();
        check_line(pf_start);                   // frame end goes back to the start
    endtask

    task automatic test_blank();
        pf_blank <= 1'b1;
        repeat (320) @(negedge clk);            // let the current line finish
        for (int i = 0; i < 320; i++) begin
            @(negedge clk);
            check_value(32'(vram_sel), 32'd0, "select while blanked");
            check_value(32'(pf_color_index), 32'(border ^ pf_colorbase), "blanked colour");
        end
        pf_blank <= 1'b0;
    endtask

    initial begin
        seed         = 32'h6c24;
        error_count  = 0;
        pf_bpp       = playfield_pkg::BPP_8;
        pf_start     = 16'h0100;
        pf_line_len  = 16'd64;                  // longer than one line of 8 bpp reads
        pf_colorbase = 8'h21;
        border       = 8'hEE;
        pf_h_repeat  = 2'd0;
        pf_v_repeat  = 2'd0;
        pf_blank     = 1'b0;
        fill_memory();
        test_reset();
        test_8bpp();
        test_modes();
        test_vrepeat();
        test_blank();
        if (error_count == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("Simulation FAILED");
            $fatal(1, "checks failed");
        end
    end

endmodule

/* testbench/playfield_sva.sv */
// assertions on the fetch FSM, bound into every bitmap_fetch instance
// select must follow an open fetch window by two cycles
module playfield_sva (
    input logic       clk,
    input logic       reset_i,
    input logic       fetch_active_i,
    input logic       vram_sel_i,
    input logic [2:0] state_i
);
    sel_low_in_reset: assert property (
        @(posedge clk) reset_i |=> !vram_sel_i
    ) else $error("video RAM select high during reset");

    // no read once the window has been closed for two cycles
    sel_in_window: assert property (
        @(posedge clk) disable iff (reset_i)
        vram_sel_i |-> $past(fetch_active_i, 2)
    ) else $error("video RAM select outside the fetch window");

    legal_state: assert property (
        @(posedge clk) disable iff (reset_i)
        state_i <= 3'd6                         // FETCH_READ_3 is the last encoding
    ) else $error("fetch FSM in an illegal state");

endmodule

bind bitmap_fetch playfield_sva sva0 (
    .clk(clk),
    .reset_i(reset_i),
    .fetch_active_i(fetch_active_i),
    .vram_sel_i(vram_sel_o),
    .state_i(state)
);

/* testbench/tb_clock.sv */
// free running testbench clock, period 40 time units
// reset is released on a falling edge after 16 cycles
module tb_clock #(
    parameter int HALF_PERIOD  = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic reset_o
);
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        reset_o = 1'b1;                         // held from time zero
        repeat (RESET_CYCLES) @(negedge clk);
        reset_o <= 1'b0;
    end

endmodule

/* design/video_playfield.sv */
// bitmap playfield top, fetches ahead from video RAM and scans out indices
// video RAM returns data the cycle after select, sampled at the next edge
module video_playfield #(
    parameter int TOTAL_WIDTH     = 800,
    parameter int OFFSCREEN_WIDTH = 160
) (
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic                  v_visible_i,
    input  wire playfield_pkg::hres_t  h_count_i,
    input  wire logic                  h_line_last_pixel_i,
    input  wire logic                  last_frame_pixel_i,
    input  wire playfield_pkg::color_t border_color_i,
    input  wire playfield_pkg::hres_t  vid_left_i,
    input  wire playfield_pkg::hres_t  vid_right_i,
    output      logic                  vram_sel_o,
    output      playfield_pkg::addr_t  vram_addr_o,
    input  wire playfield_pkg::word_t  vram_data_i,
    input  wire logic                  pf_blank_i,
    input  wire playfield_pkg::addr_t  pf_start_addr_i,
    input  wire playfield_pkg::word_t  pf_line_len_i,
    input  wire playfield_pkg::color_t pf_colorbase_i,
    input  wire playfield_pkg::bpp_t   pf_bpp_i,
    input  wire logic [1:0]            pf_h_repeat_i,
    input  wire logic [1:0]            pf_v_repeat_i,
    output      playfield_pkg::color_t pf_color_index_o
);
    logic                   fetch_active;
    logic                   line_fetch_start;
    logic                   scanout_start;
    logic                   scanout_end;
    playfield_pkg::addr_t   line_start;
    logic                   words_ready;
    playfield_pkg::word_t   data_word0, data_word1, data_word2, data_word3;
    playfield_pkg::word_t   attr;
    playfield_pkg::pixels_t pixels_buf;
    logic                   buf_full;
    logic                   buf_taken;

    line_timing #(
        .TOTAL_WIDTH(TOTAL_WIDTH),
        .OFFSCREEN_WIDTH(OFFSCREEN_WIDTH)
    ) timing0 (
        .clk(clk), .reset_i(reset_i), .h_count_i(h_count_i),
        .v_visible_i(v_visible_i), .pf_blank_i(pf_blank_i),
        .vid_left_i(vid_left_i), .vid_right_i(vid_right_i),
        .fetch_active_o(fetch_active), .line_fetch_start_o(line_fetch_start),
        .scanout_start_o(scanout_start), .scanout_end_o(scanout_end)
    );

    line_address address0 (
        .clk(clk), .reset_i(reset_i), .h_line_last_pixel_i(h_line_last_pixel_i),
        .last_frame_pixel_i(last_frame_pixel_i), .pf_blank_i(pf_blank_i),
        .pf_start_addr_i(pf_start_addr_i), .pf_line_len_i(pf_line_len_i),
        .pf_v_repeat_i(pf_v_repeat_i), .line_start_o(line_start)
    );

    bitmap_fetch fetch0 (
        .clk(clk), .reset_i(reset_i), .fetch_active_i(fetch_active),
        .line_fetch_start_i(line_fetch_start), .h_line_last_pixel_i(h_line_last_pixel_i),
        .line_start_i(line_start), .pf_bpp_i(pf_bpp_i), .buf_full_i(buf_full),
        .vram_data_i(vram_data_i), .vram_sel_o(vram_sel_o), .vram_addr_o(vram_addr_o),
        .words_ready_o(words_ready), .data_word0_o(data_word0), .data_word1_o(data_word1),
        .data_word2_o(data_word2), .data_word3_o(data_word3), .attr_o(attr)
    );

    pixel_expand expand0 (
        .clk(clk), .reset_i(reset_i), .words_ready_i(words_ready),
        .line_fetch_start_i(line_fetch_start), .buf_taken_i(buf_taken),
        .pf_bpp_i(pf_bpp_i), .data_word0_i(data_word0), .data_word1_i(data_word1),
        .data_word2_i(data_word2), .data_word3_i(data_word3), .attr_i(attr),
        .pixels_buf_o(pixels_buf), .buf_full_o(buf_full)
    );

    pixel_scanout scanout0 (
        .clk(clk), .reset_i(reset_i), .scanout_start_i(scanout_start),
        .scanout_end_i(scanout_end), .line_fetch_start_i(line_fetch_start),
        .h_line_last_pixel_i(h_line_last_pixel_i), .pixels_buf_i(pixels_buf),
        .border_color_i(border_color_i), .pf_colorbase_i(pf_colorbase_i),
        .pf_h_repeat_i(pf_h_repeat_i), .buf_taken_o(buf_taken),
        .pf_color_index_o(pf_color_index_o)
    );

endmodule

/* design/pixel_scanout.sv */
// pixel shift register with integer horizontal repeat
// border colour fills in behind each shifted pixel
module pixel_scanout (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   scanout_start_i,
    input  wire logic                   scanout_end_i,
    input  wire logic                   line_fetch_start_i,
    input  wire logic                   h_line_last_pixel_i,
    input  wire playfield_pkg::pixels_t pixels_buf_i,
    input  wire playfield_pkg::color_t  border_color_i,
    input  wire playfield_pkg::color_t  pf_colorbase_i,
    input  wire logic [1:0]             pf_h_repeat_i,
    output      logic                   buf_taken_o,
    output      playfield_pkg::color_t  pf_color_index_o
);
    logic                   scanout;            // shifting pixels out
    logic [1:0]             h_count;            // repeat countdown of current pixel
    logic [2:0]             column;             // pixel within the group
    playfield_pkg::pixels_t pixels;
    logic                   group_done;

    assign group_done       = scanout && h_count == 2'b00 && column == 3'd7;
    assign buf_taken_o      = scanout_start_i | group_done;
    assign pf_color_index_o = pixels[63:56] ^ pf_colorbase_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            scanout <= 1'b0;
            h_count <= '0;
            column  <= '0;
            pixels  <= '0;
        end else begin
            if (scanout) begin
                if (h_count != 2'b00) begin
                    h_count <= h_count - 2'd1;  // hold pixel
                end else begin
                    h_count <= pf_h_repeat_i;
                    column  <= column + 3'd1;
                    pixels  <= group_done ? pixels_buf_i :
                               {pixels[55:0], border_color_i};
                end
            end
            if (line_fetch_start_i) begin
                pixels[63:56] <= border_color_i;    // border even when blanked
            end
            if (scanout_start_i) begin
                scanout <= 1'b1;
                column  <= '0;
                h_count <= pf_h_repeat_i;
                pixels  <= pixels_buf_i;        // preloaded first group
            end
            if (scanout_end_i) begin
                scanout       <= 1'b0;
                pixels[63:56] <= border_color_i;
            end
            if (h_line_last_pixel_i) begin
                scanout <= 1'b0;
            end
        end
    end

endmodule

/* design/pixel_expand.sv */
// expands fetched words into eight 8-bit indices
// 4 bpp indices have a zero upper nibble, 8 bpp bytes pass as they are
module pixel_expand (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   words_ready_i,
    input  wire logic                   line_fetch_start_i,
    input  wire logic                   buf_taken_i,
    input  wire playfield_pkg::bpp_t    pf_bpp_i,
    input  wire playfield_pkg::word_t   data_word0_i,
    input  wire playfield_pkg::word_t   data_word1_i,
    input  wire playfield_pkg::word_t   data_word2_i,
    input  wire playfield_pkg::word_t   data_word3_i,
    input  wire playfield_pkg::word_t   attr_i,
    output      playfield_pkg::pixels_t pixels_buf_o,
    output      logic                   buf_full_o
);
    playfield_pkg::pixels_t expanded;
    logic [31:0]            nibbles;            // words 0 and 1 for 4 bpp

    assign nibbles = {data_word0_i, data_word1_i};

    always_comb begin
        expanded = '0;
        case (pf_bpp_i)
            playfield_pkg::BPP_1_ATTR: begin
                for (int i = 0; i < 8; i++) begin
                    expanded[i*8 +: 8] = {4'h0, data_word0_i[i] ?
                                         attr_i[playfield_pkg::ATTR_FORE +: 4] :
                                         attr_i[playfield_pkg::ATTR_BACK +: 4]};
                end
            end
            playfield_pkg::BPP_4: begin
                for (int i = 0; i < 8; i++) begin
                    expanded[i*8 +: 8] = {4'h0, nibbles[i*4 +: 4]};
                end
            end
            default: expanded = {data_word0_i, data_word1_i, data_word2_i, data_word3_i};
        endcase
    end

    always_ff @(posedge clk) begin
        if (words_ready_i) begin
            pixels_buf_o <= expanded;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || line_fetch_start_i) begin
            buf_full_o <= 1'b0;                 // new line starts empty
        end else if (words_ready_i) begin
            buf_full_o <= 1'b1;
        end else if (buf_taken_i) begin
            buf_full_o <= 1'b0;
        end
    end

endmodule

/* design/bitmap_fetch.sv */
// video RAM fetch FSM, one to four word reads per 8 pixel group
// read data is sampled two edges after the select edge
// first group of a line gives no words_ready, it is preloaded at scanout start
module bitmap_fetch (
    input  wire logic                 clk,
    input  wire logic                 reset_i,
    input  wire logic                 fetch_active_i,
    input  wire logic                 line_fetch_start_i,
    input  wire logic                 h_line_last_pixel_i,
    input  wire playfield_pkg::addr_t line_start_i,
    input  wire playfield_pkg::bpp_t  pf_bpp_i,
    input  wire logic                 buf_full_i,
    input  wire playfield_pkg::word_t vram_data_i,
    output      logic                 vram_sel_o,
    output      playfield_pkg::addr_t vram_addr_o,
    output      logic                 words_ready_o,
    output      playfield_pkg::word_t data_word0_o,
    output      playfield_pkg::word_t data_word1_o,
    output      playfield_pkg::word_t data_word2_o,
    output      playfield_pkg::word_t data_word3_o,
    output      playfield_pkg::word_t attr_o
);
    playfield_pkg::fetch_state_t state, state_next;
    playfield_pkg::addr_t        disp_addr;     // next display word to read
    logic                        issue;         // start a read this cycle
    logic                        first_buf;     // first group of the line pending
    logic                        is_1bpp;
    logic                        is_4bpp;

    assign is_1bpp = (pf_bpp_i == playfield_pkg::BPP_1_ATTR);
    assign is_4bpp = (pf_bpp_i == playfield_pkg::BPP_4);

    always_comb begin
        state_next = state;
        issue      = 1'b0;
        case (state)
            playfield_pkg::FETCH_IDLE: begin
                if (fetch_active_i) begin
                    state_next = playfield_pkg::FETCH_ADDR;
                end
            end
            playfield_pkg::FETCH_ADDR: begin
                if (!fetch_active_i) begin
                    state_next = playfield_pkg::FETCH_IDLE;     // window closed
                end else if (!buf_full_i) begin
                    issue      = 1'b1;                          // word 0
                    state_next = playfield_pkg::FETCH_WAIT;
                end
            end
            playfield_pkg::FETCH_WAIT: begin
                issue      = !is_1bpp;                          // word 1
                state_next = playfield_pkg::FETCH_READ_0;
            end
            playfield_pkg::FETCH_READ_0: begin
                issue      = !is_1bpp && !is_4bpp;              // word 2 for 8 bpp
                state_next = is_1bpp ? playfield_pkg::FETCH_ADDR :
                                       playfield_pkg::FETCH_READ_1;
            end
            playfield_pkg::FETCH_READ_1: begin
                issue      = !is_4bpp;                          // word 3 for 8 bpp
                state_next = is_4bpp ? playfield_pkg::FETCH_ADDR :
                                       playfield_pkg::FETCH_READ_2;
            end
            playfield_pkg::FETCH_READ_2: begin
                state_next = playfield_pkg::FETCH_READ_3;
            end
            playfield_pkg::FETCH_READ_3: begin
                state_next = playfield_pkg::FETCH_ADDR;
            end
            default: begin
                state_next = playfield_pkg::FETCH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state         <= playfield_pkg::FETCH_IDLE;
            disp_addr     <= '0;
            first_buf     <= 1'b0;
            words_ready_o <= 1'b0;
            vram_sel_o    <= 1'b0;
            vram_addr_o   <= '0;
        end else begin
            state         <= state_next;
            vram_sel_o    <= issue;
            words_ready_o <= (state == playfield_pkg::FETCH_WAIT) && !first_buf;  // prior group done
            if (state == playfield_pkg::FETCH_WAIT) begin
                first_buf <= 1'b0;
            end
            if (issue) begin
                vram_addr_o <= disp_addr;
                disp_addr   <= disp_addr + 16'd1;
            end
            if (line_fetch_start_i) begin
                first_buf <= 1'b1;
                disp_addr <= line_start_i;
            end
            if (h_line_last_pixel_i) begin
                disp_addr <= line_start_i;      // rewind for a repeated line
            end
        end
    end

    // read data capture
    always_ff @(posedge clk) begin
        case (state)
            playfield_pkg::FETCH_READ_0: begin
                data_word0_o <= vram_data_i;
                attr_o       <= vram_data_i;    // 1 bpp attribute lives in word 0
            end
            playfield_pkg::FETCH_READ_1: data_word1_o <= vram_data_i;
            playfield_pkg::FETCH_READ_2: data_word2_o <= vram_data_i;
            playfield_pkg::FETCH_READ_3: data_word3_o <= vram_data_i;
            default: ;
        endcase
    end

endmodule

/* design/line_address.sv */
// per-line display start address with integer vertical repeat
// frame end and blank both return to the frame start address
module line_address (
    input  wire logic                 clk,
    input  wire logic                 reset_i,
    input  wire logic                 h_line_last_pixel_i,
    input  wire logic                 last_frame_pixel_i,
    input  wire logic                 pf_blank_i,
    input  wire playfield_pkg::addr_t pf_start_addr_i,
    input  wire playfield_pkg::word_t pf_line_len_i,
    input  wire logic [1:0]           pf_v_repeat_i,
    output      playfield_pkg::addr_t line_start_o
);
    logic [1:0] v_count;                        // lines left before advancing

    always_ff @(posedge clk) begin
        if (reset_i) begin
            line_start_o <= '0;
            v_count      <= '0;
        end else if (pf_blank_i || last_frame_pixel_i) begin
            line_start_o <= pf_start_addr_i;    // back to top of frame
            v_count      <= pf_v_repeat_i;
        end else if (h_line_last_pixel_i) begin
            if (v_count != 2'b00) begin
                v_count <= v_count - 2'd1;      // same line data again
            end else begin
                v_count      <= pf_v_repeat_i;
                line_start_o <= line_start_o + pf_line_len_i;   // next bitmap line
            end
        end
    end

endmodule

/* design/line_timing.sv */
// fetch and scanout windows derived from the horizontal count
// scanout edges are sampled once per line, when the fetch window opens
module line_timing #(
    parameter int TOTAL_WIDTH     = 800,
    parameter int OFFSCREEN_WIDTH = 160
) (
    input  wire logic                 clk,
    input  wire logic                 reset_i,
    input  wire playfield_pkg::hres_t h_count_i,
    input  wire logic                 v_visible_i,
    input  wire logic                 pf_blank_i,
    input  wire playfield_pkg::hres_t vid_left_i,
    input  wire playfield_pkg::hres_t vid_right_i,
    output      logic                 fetch_active_o,
    output      logic                 line_fetch_start_o,
    output      logic                 scanout_start_o,
    output      logic                 scanout_end_o
);
    localparam playfield_pkg::hres_t H_MEM_BEGIN =
        playfield_pkg::hres_t'(OFFSCREEN_WIDTH - playfield_pkg::MEM_LEAD);
    localparam playfield_pkg::hres_t H_MEM_END =
        playfield_pkg::hres_t'(TOTAL_WIDTH - playfield_pkg::MEM_TAIL);
    localparam playfield_pkg::hres_t H_SCANOUT_BEGIN =
        playfield_pkg::hres_t'(OFFSCREEN_WIDTH - playfield_pkg::SCANOUT_LEAD);

    playfield_pkg::hres_t toggle_hcount;        // next count at which fetch window flips
    playfield_pkg::hres_t start_hcount;         // latched scanout start count
    playfield_pkg::hres_t end_hcount;           // latched scanout end count
    logic                 fetch_next;

    assign toggle_hcount      = fetch_active_o ? H_MEM_END : H_MEM_BEGIN;
    assign fetch_next         = (v_visible_i && h_count_i == toggle_hcount) ?
                                ~fetch_active_o : fetch_active_o;
    assign line_fetch_start_o = ~fetch_active_o & fetch_next;     // window opening cycle
    assign scanout_start_o    = (h_count_i == start_hcount) & fetch_active_o;
    assign scanout_end_o      = (h_count_i == end_hcount);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fetch_active_o <= 1'b0;
            start_hcount   <= '0;
            end_hcount     <= '0;
        end else begin
            fetch_active_o <= fetch_next & ~pf_blank_i;         // blank keeps fetch off
            if (line_fetch_start_o) begin
                start_hcount <= H_SCANOUT_BEGIN + vid_left_i;
                end_hcount   <= H_SCANOUT_BEGIN + vid_right_i;
            end
        end
    end

endmodule

/* design/playfield_pkg.sv */
// shared types and constants of the bitmap playfield generator
// bitmap modes only, no tiled text and no audio slot
package playfield_pkg;

    typedef logic [15:0] addr_t;                // video RAM word address
    typedef logic [15:0] word_t;                // video RAM data word
    typedef logic [7:0]  color_t;               // colour index
    typedef logic [10:0] hres_t;                // horizontal pixel count
    typedef logic [63:0] pixels_t;              // 8 indices, leftmost in top byte

    typedef enum logic [1:0] {
        BPP_1_ATTR = 2'd0,                      // 1 bpp with fore/back attribute byte
        BPP_4      = 2'd1,
        BPP_8      = 2'd2,
        BPP_XX     = 2'd3                       // treated like BPP_8
    } bpp_t;

    typedef enum logic [2:0] {
        FETCH_IDLE   = 3'd0,
        FETCH_ADDR   = 3'd1,                    // issue first read of a group
        FETCH_WAIT   = 3'd2,                    // first read in flight
        FETCH_READ_0 = 3'd3,
        FETCH_READ_1 = 3'd4,
        FETCH_READ_2 = 3'd5,
        FETCH_READ_3 = 3'd6
    } fetch_state_t;

    localparam int MEM_LEAD     = 64;           // fetch opens this early before visible area
    localparam int MEM_TAIL     = 8;            // fetch closes this early before line total
    localparam int SCANOUT_LEAD = 2;            // scanout starts ahead of left edge
    localparam int ATTR_FORE    = 12;           // foreground nibble in 1 bpp word
    localparam int ATTR_BACK    = 8;            // background nibble in 1 bpp word

endpackage
